/* src.f */
+incdir+sim
hdl/jtag_scope_pkg.sv
hdl/jtag_line_capture.sv
hdl/beam_timing.sv
hdl/hex_text_render.sv
hdl/jtag_hex_scope.sv
sim/tb_jtag_hex_scope.sv

/* sim/scope_model.svh */
`ifndef SCOPE_MODEL_SVH
`define SCOPE_MODEL_SVH

// frame of the DUT with its default parameters
localparam int h_active     = 160;
localparam int h_total      = 176;
localparam int hsync_start  = 164;
localparam int hsync_len    = 4;
localparam int v_active     = 40;
localparam int v_total      = 44;
localparam int vsync_start  = 41;
localparam int vsync_len    = 2;
localparam int text_w       = 128;  // 16 cells of 8 pixels
localparam int text_h       = 32;
localparam int frame_cycles = h_total * v_total;

// captured probe history as the testbench drove it
logic [capture_bits-1:0] m_tms_hist;
logic [capture_bits-1:0] m_tdi_hist;
logic [capture_bits-1:0] m_tdo_hist;
logic [capture_bits-1:0] m_count;

function automatic void clear_history();
  m_tms_hist = '0;
  m_tdi_hist = '0;
  m_tdo_hist = '0;
  m_count    = '0;
endfunction

// one rising tck: newest sample at bit 0
function automatic void shift_history(input logic s_tms, input logic s_tdi, input logic s_tdo);
  m_tms_hist = {m_tms_hist[capture_bits-2:0], s_tms};
  m_tdi_hist = {m_tdi_hist[capture_bits-2:0], s_tdi};
  m_tdo_hist = {m_tdo_hist[capture_bits-2:0], s_tdo};
  m_count    = m_count + 1;
endfunction

function automatic logic blank_at(input int x, input int y);
  return (x >= h_active) || (y >= v_active);
endfunction

function automatic logic hsync_at(input int x);
  return (x >= hsync_start) && (x < hsync_start + hsync_len);
endfunction

function automatic logic vsync_at(input int y);
  return (y >= vsync_start) && (y < vsync_start + vsync_len);
endfunction

// colour expected at raster position x, y
function automatic color_t color_at(input int x, input int y);
  int row;
  int col;
  int gx;
  logic [capture_bits-1:0] word;
  logic [3:0] nib;
  logic [4:0] bits;
  if (blank_at(x, y)) return '0;
  if (x >= text_w || y >= text_h) return bg_color;  // active but outside the text
  row = y / cell_px;
  col = x / cell_px;
  gx  = x % cell_px;
  case (row)
    0: word = m_count;
    1: word = m_tms_hist;
    2: word = m_tdi_hist;
    default: word = m_tdo_hist;
  endcase
  nib = word[capture_bits - 1 - 4 * col -: 4];  // leftmost digit is the top nibble
  if (gx >= 5) return bg_color;                 // gap between glyphs
  bits = hex_glyph(nib, 3'(y % cell_px));
  return bits[4 - gx] ? row_palette[row] : bg_color;
endfunction

`endif

/* sim/tb_jtag_hex_scope.sv */
`timescale 1ns/10ps

module tb_jtag_hex_scope;
  import jtag_scope_pkg::*;

  `include "scope_model.svh"

  localparam int m_none = 0;  // checker modes
  localparam int m_timing = 1;
  localparam int m_full = 2;
  localparam int m_outside = 3;
  localparam int planned_cycles = 4 * frame_cycles + 8 * (40 + 150 + 64 + 968) + 3 * 16 + 64;
  localparam int timeout_limit = planned_cycles * 11 / 10;
  localparam int f_glyph_pixels = 14;  // lit pixels in an F

  logic clk, arst_n, tck, tms, tdi, tdo;
  color_t pixel_color;
  logic pixel_blank, pixel_hsync, pixel_vsync;

  int cycle_n;      // clock edges since reset release
  int run_cycles = 0;
  int check_mode = m_none;
  int error_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int f_pixels;
  int errs_at_start;
  int chk_x, chk_y;
  logic exp_blank, exp_hsync, exp_vsync, in_text;
  color_t exp_color;

  jtag_hex_scope u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .tck         (tck),
    .tms         (tms),
    .tdi         (tdi),
    .tdo         (tdo),
    .pixel_color (pixel_color),
    .pixel_blank (pixel_blank),
    .pixel_hsync (pixel_hsync),
    .pixel_vsync (pixel_vsync)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) cycle_n = 0;
    else cycle_n = cycle_n + 1;
  end

  always @(posedge clk) begin
    run_cycles = run_cycles + 1;
    if (run_cycles > timeout_limit) begin
      $display("timeout: run passed %0d clock cycles without finishing", timeout_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    error_count = error_count + 1;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // outputs are stable at the falling edge, position is two cycles behind
  always @(negedge clk) begin
    if (check_mode != m_none) begin
      if (cycle_n < 2) begin
        chk_x = 0;
        chk_y = 0;
        exp_blank = 1'b1;
        exp_hsync = 1'b0;
        exp_vsync = 1'b0;
        exp_color = '0;
        in_text = 1'b0;
      end else begin
        chk_x = (cycle_n - 2) % h_total;
        chk_y = ((cycle_n - 2) / h_total) % v_total;
        exp_blank = blank_at(chk_x, chk_y);
        exp_hsync = hsync_at(chk_x);
        exp_vsync = vsync_at(chk_y);
        exp_color = color_at(chk_x, chk_y);
        in_text = (chk_x < text_w) && (chk_y < text_h);
      end
      if ({pixel_blank, pixel_hsync, pixel_vsync} !== {exp_blank, exp_hsync, exp_vsync})
        report_error($sformatf("blank/hsync/vsync %b%b%b, expected %b%b%b at x=%0d y=%0d",
          pixel_blank, pixel_hsync, pixel_vsync, exp_blank, exp_hsync, exp_vsync,
          chk_x, chk_y));
      if (check_mode == m_full || exp_blank || (check_mode == m_outside && !in_text)) begin
        if (pixel_color !== exp_color)
          report_error($sformatf("colour %h, expected %h at x=%0d y=%0d",
            pixel_color, exp_color, chk_x, chk_y));
      end
      if (check_mode == m_full && in_text && chk_y >= 24 && pixel_color == row_palette[3])
        f_pixels = f_pixels + 1;  // row 3 foreground
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    tck    <= 1'b0;  // no tck edge across the reset release
    clear_history();
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  // each edge: 4 cycles low with new data, then 4 cycles high
  task automatic drive_edges(input int count, input bit hold_tdo);
    logic b_tms, b_tdi, b_tdo;
    for (int i = 0; i < count; i++) begin
      b_tms = $urandom;
      b_tdi = $urandom;
      b_tdo = hold_tdo ? 1'b1 : 1'($urandom);
      @(posedge clk);
      tck <= 1'b0;
      tms <= b_tms;
      tdi <= b_tdi;
      tdo <= b_tdo;
      repeat (4) @(posedge clk);
      tck <= 1'b1;
      shift_history(b_tms, b_tdi, b_tdo);
      repeat (3) @(posedge clk);
    end
  endtask

  task automatic check_frame(input int mode, input int cycles);
    check_mode = mode;
    repeat (cycles) @(posedge clk);
    check_mode = m_none;
  endtask

  task automatic start_test();
    errs_at_start = error_count;
  endtask

  task automatic end_test(input string name);
    if (error_count == errs_at_start) begin
      pass_count = pass_count + 1;
      $display("test %s: pass", name);
    end else begin
      fail_count = fail_count + 1;
      $display("test %s: fail, %0d errors", name, error_count - errs_at_start);
    end
  endtask

  initial begin
    arst_n = 1'b0;
    tck = 1'b0;
    tms = 1'b0;
    tdi = 1'b0;
    tdo = 1'b0;
    void'($urandom(32'h3c6780b0));
    clear_history();
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    start_test();
    check_frame(m_timing, frame_cycles + 2);  // includes the two reset cycles
    end_test("1 reset and raster timing");

    start_test();
    apply_reset();
    drive_edges(40, 1'b0);
    repeat (16) @(posedge clk);
    check_frame(m_full, frame_cycles);
    end_test("2 burst of 40 edges");

    start_test();
    apply_reset();
    drive_edges(150, 1'b0);
    repeat (16) @(posedge clk);
    check_frame(m_full, frame_cycles);
    end_test("3 burst of 150 edges");

    start_test();
    apply_reset();
    drive_edges(64, 1'b1);
    repeat (16) @(posedge clk);
    f_pixels = 0;
    check_frame(m_full, frame_cycles);
    if (f_pixels != row_digits * f_glyph_pixels)
      report_error($sformatf("row 3 shows %0d foreground pixels, expected %0d",
        f_pixels, row_digits * f_glyph_pixels));
    end_test("4 tdo held high");

    start_test();
    @(posedge clk);
    check_mode = m_outside;
    drive_edges(968, 1'b0);
    check_mode = m_none;
    end_test("5 border during burst");

    $display("tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count,
      error_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* hdl/jtag_hex_scope.sv */
`timescale 1ns/10ps

module jtag_hex_scope #(
  parameter int H_ACTIVE    = 160,
  parameter int H_TOTAL     = 176,
  parameter int HSYNC_START = 164,
  parameter int HSYNC_LEN   = 4,
  parameter int V_ACTIVE    = 40,
  parameter int V_TOTAL     = 44,
  parameter int VSYNC_START = 41,
  parameter int VSYNC_LEN   = 2
) (
  input  logic clk,
  input  logic arst_n,
  input  logic tck,
  input  logic tms,
  input  logic tdi,
  input  logic tdo,
  output jtag_scope_pkg::color_t pixel_color,
  output logic pixel_blank,
  output logic pixel_hsync,
  output logic pixel_vsync
);
  import jtag_scope_pkg::*;

  logic [capture_bits-1:0] tms_hist;
  logic [capture_bits-1:0] tdi_hist;
  logic [capture_bits-1:0] tdo_hist;
  logic [capture_bits-1:0] edge_count;
  logic [display_bits-1:0] display;

  logic [7:0] beam_x;
  logic [7:0] beam_y;
  logic       blank;
  logic       hsync;
  logic       vsync;

  jtag_line_capture u_capture (
    .clk        (clk),
    .arst_n     (arst_n),
    .tck        (tck),
    .tms        (tms),
    .tdi        (tdi),
    .tdo        (tdo),
    .tms_hist   (tms_hist),
    .tdi_hist   (tdi_hist),
    .tdo_hist   (tdo_hist),
    .edge_count (edge_count)
  );

  // row 0 in the low 64 bits: count, then tms, tdi, tdo
  assign display = {tdo_hist, tdi_hist, tms_hist, edge_count};

  beam_timing #(
    .H_ACTIVE    (H_ACTIVE),
    .H_TOTAL     (H_TOTAL),
    .HSYNC_START (HSYNC_START),
    .HSYNC_LEN   (HSYNC_LEN),
    .V_ACTIVE    (V_ACTIVE),
    .V_TOTAL     (V_TOTAL),
    .VSYNC_START (VSYNC_START),
    .VSYNC_LEN   (VSYNC_LEN)
  ) u_beam (
    .clk    (clk),
    .arst_n (arst_n),
    .beam_x (beam_x),
    .beam_y (beam_y),
    .blank  (blank),
    .hsync  (hsync),
    .vsync  (vsync)
  );

  hex_text_render u_render (
    .clk         (clk),
    .arst_n      (arst_n),
    .display     (display),
    .beam_x      (beam_x),
    .beam_y      (beam_y),
    .blank       (blank),
    .hsync       (hsync),
    .vsync       (vsync),
    .pixel_color (pixel_color),
    .pixel_blank (pixel_blank),
    .pixel_hsync (pixel_hsync),
    .pixel_vsync (pixel_vsync)
  );

endmodule

/* hdl/hex_text_render.sv */
`timescale 1ns/10ps

module hex_text_render (
  input  logic clk,
  input  logic arst_n,
  input  logic [jtag_scope_pkg::display_bits-1:0] display,
  input  logic [7:0] beam_x,
  input  logic [7:0] beam_y,
  input  logic blank,
  input  logic hsync,
  input  logic vsync,
  output jtag_scope_pkg::color_t pixel_color,
  output logic pixel_blank,
  output logic pixel_hsync,
  output logic pixel_vsync
);
  import jtag_scope_pkg::*;

  localparam int text_w = row_digits * cell_px;  // 128
  localparam int text_h = text_rows * cell_px;   // 32
  localparam int idx_w  = $clog2(display_bits);

  logic [3:0]       digit_col;
  logic [1:0]       text_row;
  logic [idx_w-1:0] nib_lsb;

  logic [3:0] s1_nibble;
  logic [2:0] s1_glyph_row;
  logic [2:0] s1_px_col;
  logic       s1_in_area;
  logic [1:0] s1_pal_idx;
  logic       s1_blank;
  logic       s1_hsync;
  logic       s1_vsync;

  logic [4:0] glyph_bits;
  logic       fg;
  color_t     next_color;

  assign digit_col = beam_x[6:3];
  assign text_row  = beam_y[4:3];

  // column 0 is the most significant digit of its row
  assign nib_lsb = idx_w'(text_row * row_digits * 4 + (row_digits - 1 - digit_col) * 4);

  // stage 1: pick the nibble and the position inside the cell
  always_ff @(posedge clk) begin
    s1_nibble    <= display[nib_lsb +: 4];
    s1_glyph_row <= beam_y[2:0];
    s1_px_col    <= beam_x[2:0];
    s1_in_area   <= (beam_x < text_w) && (beam_y < text_h);
    s1_pal_idx   <= text_row;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_blank <= 1'b1;
      s1_hsync <= 1'b0;
      s1_vsync <= 1'b0;
    end else begin
      s1_blank <= blank;
      s1_hsync <= hsync;
      s1_vsync <= vsync;
    end
  end

  // stage 2: glyph lookup and colour select
  assign glyph_bits = hex_glyph(s1_nibble, s1_glyph_row);
  assign fg = (s1_px_col < 3'd5) ? glyph_bits[3'd4 - s1_px_col] : 1'b0;  // cols 5..7 are gap

  assign next_color = s1_blank ? color_t'(0) :
                      (s1_in_area && fg) ? row_palette[s1_pal_idx] : bg_color;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pixel_color <= '0;
      pixel_blank <= 1'b1;
      pixel_hsync <= 1'b0;
      pixel_vsync <= 1'b0;
    end else begin
      pixel_color <= next_color;
      pixel_blank <= s1_blank;
      pixel_hsync <= s1_hsync;
      pixel_vsync <= s1_vsync;
    end
  end

  a_blank_black: assert property (
    @(posedge clk) disable iff (!arst_n)
    pixel_blank |-> (pixel_color == '0)
  ) else $error("non-zero colour on a blank pixel");

endmodule

/* hdl/beam_timing.sv */
`timescale 1ns/10ps

module beam_timing #(
  parameter int H_ACTIVE    = 160,
  parameter int H_TOTAL     = 176,
  parameter int HSYNC_START = 164,
  parameter int HSYNC_LEN   = 4,
  parameter int V_ACTIVE    = 40,
  parameter int V_TOTAL     = 44,
  parameter int VSYNC_START = 41,
  parameter int VSYNC_LEN   = 2
) (
  input  logic       clk,
  input  logic       arst_n,
  output logic [7:0] beam_x,
  output logic [7:0] beam_y,
  output logic       blank,
  output logic       hsync,
  output logic       vsync
);

  logic line_end;  // last pixel of the line

  assign line_end = (beam_x == 8'(H_TOTAL - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beam_x <= '0;
      beam_y <= '0;
    end else begin
      if (line_end) begin
        beam_x <= '0;
        if (beam_y == 8'(V_TOTAL - 1)) beam_y <= '0;
        else beam_y <= beam_y + 1'b1;
      end else begin
        beam_x <= beam_x + 1'b1;
      end
    end
  end

  // decoded straight from the counters, aligned with beam_x/beam_y
  assign blank = (beam_x >= H_ACTIVE) || (beam_y >= V_ACTIVE);
  assign hsync = (beam_x >= HSYNC_START) && (beam_x < HSYNC_START + HSYNC_LEN);
  assign vsync = (beam_y >= VSYNC_START) && (beam_y < VSYNC_START + VSYNC_LEN);

  a_x_in_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    beam_x < H_TOTAL
  ) else $error("beam_x reached H_TOTAL");

endmodule

/* hdl/jtag_line_capture.sv */
`timescale 1ns/10ps

module jtag_line_capture (
  input  logic clk,
  input  logic arst_n,
  input  logic tck,
  input  logic tms,
  input  logic tdi,
  input  logic tdo,
  output logic [jtag_scope_pkg::capture_bits-1:0] tms_hist,
  output logic [jtag_scope_pkg::capture_bits-1:0] tdi_hist,
  output logic [jtag_scope_pkg::capture_bits-1:0] tdo_hist,
  output logic [jtag_scope_pkg::capture_bits-1:0] edge_count
);
  import jtag_scope_pkg::*;

  logic [3:0] probe_s1;  // {tck, tms, tdi, tdo}, first flop
  logic [3:0] probe_s2;
  logic       tck_d;     // previous synchronized tck
  logic       tck_rise;

  // two flop synchronizer on all probe lines
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      probe_s1 <= '0;
      probe_s2 <= '0;
      tck_d    <= 1'b0;
    end else begin
      probe_s1 <= {tck, tms, tdi, tdo};
      probe_s2 <= probe_s1;
      tck_d    <= probe_s2[3];
    end
  end

  assign tck_rise = probe_s2[3] & ~tck_d;  // one cycle strobe

  // newest sample goes to bit 0, oldest falls off the top
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tms_hist   <= '0;
      tdi_hist   <= '0;
      tdo_hist   <= '0;
      edge_count <= '0;
    end else if (tck_rise) begin
      tms_hist   <= {tms_hist[capture_bits-2:0], probe_s2[2]};
      tdi_hist   <= {tdi_hist[capture_bits-2:0], probe_s2[1]};
      tdo_hist   <= {tdo_hist[capture_bits-2:0], probe_s2[0]};
      edge_count <= edge_count + 1'b1;  // wraps
    end
  end

  // the counter only moves on the clock edge that follows a tck rise
  a_count_on_strobe: assert property (
    @(posedge clk) disable iff (!arst_n)
    !tck_rise |=> $stable(edge_count)
  ) else $error("edge_count changed without a tck rising edge");

endmodule

/* hdl/jtag_scope_pkg.sv */
package jtag_scope_pkg;

  localparam int capture_bits = 64;  // history depth and edge counter width
  localparam int row_digits   = 16;
  localparam int text_rows    = 4;
  localparam int display_bits = text_rows * row_digits * 4;
  localparam int cell_px      = 8;   // cell is 8x8, glyph 5x7 in the top left corner

  typedef logic [15:0] color_t;  // rgb565

  // one foreground per text row: yellow, cyan, magenta, green
  localparam color_t row_palette [text_rows] = '{16'hffe0, 16'h07ff, 16'hf81f, 16'h07e0};
  localparam color_t bg_color = 16'h0841;  // dark grey

  // returns one glyph row, bit 4 is the leftmost pixel
  function automatic logic [4:0] hex_glyph(input logic [3:0] nibble, input logic [2:0] row);
    logic [34:0] g;  // seven rows of five pixels, row 0 in the top bits
    case (nibble)
      4'h0: g = 35'b01110_10001_10011_10101_11001_10001_01110;
      4'h1: g = 35'b00100_01100_00100_00100_00100_00100_01110;
      4'h2: g = 35'b01110_10001_00001_00010_00100_01000_11111;
      4'h3: g = 35'b11111_00010_00100_00010_00001_10001_01110;
      4'h4: g = 35'b00010_00110_01010_10010_11111_00010_00010;
      4'h5: g = 35'b11111_10000_11110_00001_00001_10001_01110;
      4'h6: g = 35'b00110_01000_10000_11110_10001_10001_01110;
      4'h7: g = 35'b11111_00001_00010_00100_01000_01000_01000;
      4'h8: g = 35'b01110_10001_10001_01110_10001_10001_01110;
      4'h9: g = 35'b01110_10001_10001_01111_00001_00010_01100;
      4'ha: g = 35'b01110_10001_10001_11111_10001_10001_10001;
      4'hb: g = 35'b11110_10001_10001_11110_10001_10001_11110;
      4'hc: g = 35'b01110_10001_10000_10000_10000_10001_01110;
      4'hd: g = 35'b11100_10010_10001_10001_10001_10010_11100;
      4'he: g = 35'b11111_10000_10000_11110_10000_10000_11111;
      default: g = 35'b11111_10000_10000_11110_10000_10000_10000;
    endcase
    if (row == 3'd7) return 5'b00000;  // spacing line below the glyph
    return g[34 - 5 * row -: 5];
  endfunction

endpackage
